/* hdl/norm_check_defines.svh */
// Global constants for the ML-DSA norm-check block.
// Widths, memory geometry, the modulus and the per-mode bounds live here.
// Include this file wherever one of these macros is needed.

`ifndef NORM_CHECK_DEFINES_SVH
`define NORM_CHECK_DEFINES_SVH

// Each coefficient slot is 24 bits wide and only the low 23 bits carry data
`define NC_REG_SIZE         24
`define NC_COEFS_PER_WORD   4

// Coefficient memory geometry in words
`define NC_MEM_ADDR_WIDTH   10
`define NC_WORDS_PER_POLY   64

// ML-DSA modulus
`define NC_Q                8380417

// Number of polynomials in the z vector and in the r0 and ct0 vectors
`define NC_L                7
`define NC_K                8

// Infinity-norm bounds, gamma1 - beta, gamma2 - beta and gamma2
`define NC_Z_BOUND          524168
`define NC_R0_BOUND         261768
`define NC_CT0_BOUND        261888

`endif

/* hdl/norm_check_pkg.sv */
// Types shared by the norm-check controller, the check units and the top level.
// Modules import this package inside their body and use scoped names in their ports.

`include "norm_check_defines.svh"

package norm_check_pkg;

    // One coefficient slot as stored in memory
    typedef logic [`NC_REG_SIZE-1:0] coef_t;

    // A memory word holds four slots, slot 0 sits in the low bits
    typedef coef_t [`NC_COEFS_PER_WORD-1:0] mem_word_t;

    // Word address into the coefficient memory
    typedef logic [`NC_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Word index inside one polynomial
    // The shuffling randomness uses the same width since it is a start index
    typedef logic [$clog2(`NC_WORDS_PER_POLY)-1:0] word_idx_t;

    // Polynomial index inside a vector, sized for the longest vector
    typedef logic [$clog2(`NC_K)-1:0] poly_idx_t;

    // Which bound is applied to the vector being checked
    typedef enum logic [1:0] {
        CHK_Z   = 2'd0,
        CHK_R0  = 2'd1,
        CHK_CT0 = 2'd2
    } chk_norm_mode_t;

    // Controller FSM states
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_READ  = 2'd1,
        CTRL_FLUSH = 2'd2
    } ctrl_state_t;

    // Read request to the coefficient memory
    // The memory answers one cycle later and has no flow control
    typedef struct packed {
        logic      rd_en;
        mem_addr_t addr;
    } mem_rd_req_t;

endpackage

/* hdl/norm_check.sv */
// Single coefficient bound check.
// Centres a coefficient modulo q and compares its magnitude with the bound
// of the selected mode. Purely combinational, four of these run in parallel.

`timescale 1ns/10ps

`include "norm_check_defines.svh"

module norm_check (
    input  logic                           enable,
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  norm_check_pkg::coef_t          opa,
    output logic                           invalid
);

    import norm_check_pkg::*;

    localparam int val_width = `NC_REG_SIZE - 1;

    localparam logic [val_width-1:0] q_val  = val_width'(`NC_Q);
    localparam logic [val_width-1:0] q_half = val_width'((`NC_Q - 1) / 2);

    logic [val_width-1:0] coef_val;
    logic [val_width-1:0] centred;
    logic [val_width-1:0] bound;
    logic                 out_of_field;

    // Only the low 23 bits hold the coefficient, the top bit of the slot is spare
    assign coef_val = opa[val_width-1:0];

    // A raw value at or above q is not a reduced coefficient
    assign out_of_field = (coef_val >= q_val);

    // Upper half of the field stands for negative values
    // q - c gives their magnitude
    assign centred = (coef_val <= q_half) ? coef_val : (q_val - coef_val);

    always_comb begin
        case (mode)
            CHK_Z:   bound = val_width'(`NC_Z_BOUND);
            CHK_R0:  bound = val_width'(`NC_R0_BOUND);
            CHK_CT0: bound = val_width'(`NC_CT0_BOUND);
            // An illegal mode gives a zero bound so every coefficient fails
            default: bound = '0;
        endcase
    end

    // The bound itself already fails, the norm must be strictly below it
    assign invalid = enable & (out_of_field | (centred >= bound));

    // Mode comes from the top-level input and must be legal whenever a check runs
    always_comb begin
        if (enable) begin
            mode_legal: assert final (mode inside {CHK_Z, CHK_R0, CHK_CT0})
                else $error("norm_check: illegal mode %h during check", mode);
        end
    end

endmodule

/* hdl/norm_check_ctrl.sv */
// Read sequencer for the norm-check block.
// Walks every polynomial of the selected vector, one memory word per cycle,
// starting each polynomial at the sampled randomness and wrapping at 64.
// Raises an internal done once the last word has cleared the check units.

`timescale 1ns/10ps

`include "norm_check_defines.svh"

module norm_check_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          norm_check_enable,
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  norm_check_pkg::word_idx_t     randomness,
    input  norm_check_pkg::mem_addr_t     mem_base_addr,
    output norm_check_pkg::mem_rd_req_t   mem_rd_req,
    output logic                          check_enable,
    output logic                          norm_check_done
);

    import norm_check_pkg::*;

    localparam int word_bits = $bits(word_idx_t);

    ctrl_state_t state;
    poly_idx_t   poly_cnt;
    poly_idx_t   last_poly;
    word_idx_t   word_cnt;
    word_idx_t   rand_q;
    word_idx_t   word_idx;
    logic [1:0]  flush_cnt;
    mem_addr_t   addr_offset;

    // z has L polynomials, r0 and ct0 have K
    // Mode is held stable by the caller for the whole operation
    assign last_poly = (mode == CHK_Z) ? poly_idx_t'(`NC_L - 1) : poly_idx_t'(`NC_K - 1);

    // Rotated word index, the 6-bit add wraps modulo 64 by itself
    assign word_idx = word_cnt + rand_q;

    // Request is issued straight from the counters so it appears in every READ cycle
    assign mem_rd_req.rd_en = (state == CTRL_READ);
    assign mem_rd_req.addr  = mem_base_addr + mem_addr_t'({poly_cnt, word_idx});

    // One check per issued read, the top level lines it up with the returned data
    assign check_enable = (state == CTRL_READ);

    // FLUSH lasts three cycles
    // The second one is when the accumulated invalid flag has seen the last word
    // The third keeps the controller busy while done is registered at the top
    assign norm_check_done = (state == CTRL_FLUSH) && (flush_cnt == 2'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= CTRL_IDLE;
            poly_cnt  <= '0;
            word_cnt  <= '0;
            rand_q    <= '0;
            flush_cnt <= '0;
        end else if (zeroize) begin
            state     <= CTRL_IDLE;
            poly_cnt  <= '0;
            word_cnt  <= '0;
            rand_q    <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    // A start pulse is only honoured here, so pulses while busy are dropped
                    if (norm_check_enable) begin
                        state    <= CTRL_READ;
                        poly_cnt <= '0;
                        word_cnt <= '0;
                        rand_q   <= randomness;
                    end
                end
                CTRL_READ: begin
                    word_cnt <= word_cnt + 1'b1;
                    // Last word of this polynomial, move on to the next one
                    if (word_cnt == word_idx_t'(`NC_WORDS_PER_POLY - 1)) begin
                        poly_cnt <= poly_cnt + 1'b1;
                        if (poly_cnt == last_poly) begin
                            state     <= CTRL_FLUSH;
                            flush_cnt <= '0;
                        end
                    end
                end
                CTRL_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == 2'd2) begin
                        state <= CTRL_IDLE;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // Offset of the request from the vector base, wraps like the memory address
    assign addr_offset = mem_rd_req.addr - mem_base_addr;

    // An idle controller that sees no start must not read on the next cycle
    idle_no_read: assert property (@(posedge clk) disable iff (!reset_n)
        (state == CTRL_IDLE && !norm_check_enable) |=> !mem_rd_req.rd_en)
        else $error("norm_check_ctrl: read issued without a start");

    // Every read stays within the polynomials of the selected vector
    addr_in_window: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_req.rd_en |-> (addr_offset[`NC_MEM_ADDR_WIDTH-1:word_bits] <= last_poly))
        else $error("norm_check_ctrl: address %h outside vector window", mem_rd_req.addr);

endmodule

/* hdl/norm_check_top.sv */
// Top level of the ML-DSA norm-check block.
// A start pulse reads one vector from the coefficient memory, four coefficients
// per cycle, and reports a single invalid flag with done.
// Ready follows done by one cycle so the controller can queue the next vector.

`timescale 1ns/10ps

`include "norm_check_defines.svh"

module norm_check_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  logic                           norm_check_enable,
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  logic                           shuffling_enable,
    input  norm_check_pkg::word_idx_t      randomness,
    input  norm_check_pkg::mem_addr_t      mem_base_addr,
    output norm_check_pkg::mem_rd_req_t    mem_rd_req,
    input  norm_check_pkg::mem_word_t      mem_rd_data,
    output logic                           invalid,
    output logic                           norm_check_ready,
    output logic                           norm_check_done
);

    import norm_check_pkg::*;

    logic [`NC_COEFS_PER_WORD-1:0] check_invalid;
    logic                          check_enable;
    logic                          check_enable_q;
    logic                          done_int;
    word_idx_t                     ctrl_randomness;

    // Without shuffling every polynomial starts at word 0
    // The controller samples this only on the start cycle and holds it for the operation
    assign ctrl_randomness = shuffling_enable ? randomness : '0;

    norm_check_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .randomness        (ctrl_randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_req        (mem_rd_req),
        .check_enable      (check_enable),
        .norm_check_done   (done_int)
    );

    // One check unit per slot of the returned word
    for (genvar i = 0; i < `NC_COEFS_PER_WORD; i++) begin : g_check
        norm_check u_check (
            .enable  (check_enable_q),
            .mode    (mode),
            .opa     (mem_rd_data[i]),
            .invalid (check_invalid[i])
        );
    end

    // Memory data arrives one cycle after the request, so the enable is delayed to match
    // Done and ready are registered pulses, ready trails done by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable_q   <= 1'b0;
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else if (zeroize) begin
            check_enable_q   <= 1'b0;
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else begin
            check_enable_q   <= check_enable;
            norm_check_done  <= done_int;
            norm_check_ready <= norm_check_done;
        end
    end

    // Sticky OR over every coefficient of the vector
    // It is read by the controller while done is high and cleared right after
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || norm_check_done) begin
            invalid <= 1'b0;
        end else begin
            invalid <= invalid | (|check_invalid);
        end
    end

    // Done and ready are separate pulses and never overlap
    done_ready_excl: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done |-> !norm_check_ready)
        else $error("norm_check_top: done and ready high together");

endmodule

/* tests/tb_coef_mem.sv */
// Behavioural coefficient memory for the norm-check testbench.
// Answers every read one cycle later, is preloaded through write_coef and
// counts reads per word so a second read of a word shows up on dup_read.

`timescale 1ns/10ps

`include "norm_check_defines.svh"

module tb_coef_mem (
    input  logic                        clk,
    input  norm_check_pkg::mem_rd_req_t mem_rd_req,
    output norm_check_pkg::mem_word_t   mem_rd_data,
    output logic                        dup_read
);

    import norm_check_pkg::*;

    localparam int depth = 1 << `NC_MEM_ADDR_WIDTH;

    mem_word_t mem [depth];
    int        read_count [depth];

    // Small pattern built from the whole address, legal in every mode
    initial begin
        for (int a = 0; a < depth; a++) begin
            for (int s = 0; s < `NC_COEFS_PER_WORD; s++) begin
                mem[a][s] = coef_t'(a * `NC_COEFS_PER_WORD + s);
            end
            read_count[a] = 0;
        end
        mem_rd_data = '0;
    end

    // High when the word being requested was already read since the last clear
    assign dup_read = mem_rd_req.rd_en && (read_count[mem_rd_req.addr] != 0);

    always @(posedge clk) begin
        if (mem_rd_req.rd_en) begin
            mem_rd_data                 <= mem[mem_rd_req.addr];
            read_count[mem_rd_req.addr] <= read_count[mem_rd_req.addr] + 1;
        end
    end

    task automatic write_coef(input mem_addr_t addr, input int slot, input coef_t value);
        mem[addr][slot] = value;
    endtask

    // Called before each operation so every word starts unread
    task automatic clear_counts();
        for (int a = 0; a < depth; a++) begin
            read_count[a] = 0;
        end
    endtask

endmodule

/* tests/tb_norm_check.sv */
// Testbench for the norm-check top level.
// Runs vectors in all three modes through a behavioural memory while a cycle
// model of the protocol feeds concurrent assertions on reads, done, ready and invalid.

`timescale 1ns/10ps

`include "norm_check_defines.svh"

module tb_norm_check;

    import norm_check_pkg::*;

    localparam int wpp        = `NC_WORDS_PER_POLY;
    localparam int num_ops    = 20;
    localparam int max_cycles = num_ops * 520 + 600;

    logic           clk;
    logic           reset_n;
    logic           zeroize;
    logic           norm_check_enable;
    logic           shuffling_enable;
    chk_norm_mode_t mode;
    word_idx_t      randomness;
    mem_addr_t      mem_base_addr;
    mem_rd_req_t    mem_rd_req;
    mem_word_t      mem_rd_data;
    logic           invalid;
    logic           norm_check_ready;
    logic           norm_check_done;
    logic           dup_read;

    // Protocol model, cyc is k in the cycle after read k was requested
    logic           tracking;
    logic           ready_due;
    logic           exp_invalid;
    logic           rd_due;
    logic           done_due;
    word_idx_t      exp_r;
    int             cyc;
    int             exp_w;
    int             cycle_count = 0;
    integer         seed = 32'h97bd_5f5d;

    norm_check_top u_norm_check_top (.*);

    tb_coef_mem u_mem (
        .clk         (clk),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_data (mem_rd_data),
        .dup_read    (dup_read)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int bound_of(input chk_norm_mode_t m);
        return (m == CHK_Z) ? `NC_Z_BOUND : (m == CHK_R0) ? `NC_R0_BOUND : `NC_CT0_BOUND;
    endfunction

    function automatic int words_of(input chk_norm_mode_t m);
        return ((m == CHK_Z) ? `NC_L : `NC_K) * wpp;
    endfunction

    // Centred magnitude, values above (q-1)/2 stand for v - q
    function automatic logic out_of_bound(input int v, input chk_norm_mode_t m);
        int mag;
        mag = (v > (`NC_Q - 1) / 2) ? `NC_Q - v : v;
        return (v >= `NC_Q) || (mag >= bound_of(m));
    endfunction

    // Read k walks polynomial (k-1)/64, rotated by r inside the polynomial
    function automatic mem_addr_t expected_addr(input mem_addr_t base, input word_idx_t r,
                                                input int k);
        int j;
        j = k - 1;
        return base + mem_addr_t'((j / wpp) * wpp + ((r + j) % wpp));
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        abort_run($sformatf("[FAIL] %s: got 'h%0h, expected 'h%0h", name, got, exp));
    endtask

    // Fresh legal vector, each draw lands on the negative side half the time
    task automatic fill_vector(input chk_norm_mode_t m, input mem_addr_t base);
        int v;
        for (int w = 0; w < words_of(m); w++) begin
            for (int s = 0; s < `NC_COEFS_PER_WORD; s++) begin
                v = $unsigned($random(seed)) % bound_of(m);
                if (v != 0 && ($random(seed) % 2) != 0) begin
                    v = `NC_Q - v;
                end
                u_mem.write_coef(base + mem_addr_t'(w), s, coef_t'(v));
            end
        end
        exp_invalid = 1'b0;
    endtask

    task automatic place_coef(input chk_norm_mode_t m, input mem_addr_t base, input int v);
        int pos;
        pos = $unsigned($random(seed)) % (words_of(m) * `NC_COEFS_PER_WORD);
        u_mem.write_coef(base + mem_addr_t'(pos / 4), pos % 4, coef_t'(v));
        exp_invalid = exp_invalid | out_of_bound(v, m);
    endtask

    // Shuffle and randomness change right after the pulse, only the start value counts
    task automatic start_op(input chk_norm_mode_t m, input mem_addr_t base,
                            input logic shuffle, input word_idx_t rnd);
        @(posedge clk);
        #1;
        mode              = m;
        mem_base_addr     = base;
        shuffling_enable  = shuffle;
        randomness        = rnd;
        exp_w             = words_of(m);
        u_mem.clear_counts();
        norm_check_enable = 1'b1;
        @(posedge clk);
        #1;
        norm_check_enable = 1'b0;
        shuffling_enable  = ~shuffle;
        randomness        = word_idx_t'($random(seed));
    endtask

    task automatic wait_ready();
        do begin
            @(posedge clk);
            #1;
        end while (!norm_check_ready);
    endtask

    // An enable is only taken while no operation is tracked
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tracking  <= 1'b0;
            ready_due <= 1'b0;
            cyc       <= 0;
            exp_r     <= '0;
        end else begin
            ready_due <= done_due && !zeroize;
            if (zeroize) begin
                tracking <= 1'b0;
            end else if (norm_check_enable && !tracking) begin
                tracking <= 1'b1;
                cyc      <= 1;
                exp_r    <= shuffling_enable ? randomness : '0;
            end else if (tracking) begin
                cyc <= cyc + 1;
                if (done_due) begin
                    tracking <= 1'b0;
                end
            end
        end
    end

    assign rd_due   = tracking && (cyc <= exp_w);
    assign done_due = tracking && (cyc == exp_w + 3);

    rd_timing: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_req.rd_en == rd_due)
        else value_mismatch("mem_rd_req.rd_en", $sampled(mem_rd_req.rd_en), $sampled(rd_due));

    rd_addr: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_req.rd_en |-> mem_rd_req.addr == expected_addr(mem_base_addr, exp_r, cyc))
        else value_mismatch("mem_rd_req.addr", $sampled(mem_rd_req.addr),
            expected_addr($sampled(mem_base_addr), $sampled(exp_r), $sampled(cyc)));

    rd_once: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_req.rd_en |-> !dup_read)
        else abort_run("A memory word was read more than once in one operation");

    done_timing: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done == done_due)
        else value_mismatch("norm_check_done", $sampled(norm_check_done), $sampled(done_due));

    ready_timing: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_ready == ready_due)
        else value_mismatch("norm_check_ready", $sampled(norm_check_ready),
                            $sampled(ready_due));

    invalid_at_done: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done |-> invalid == exp_invalid)
        else value_mismatch("invalid", $sampled(invalid), $sampled(exp_invalid));

    invalid_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !tracking |-> !invalid)
        else value_mismatch("invalid", $sampled(invalid), 0);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            abort_run("Timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        mem_addr_t      bases [2];
        int             edge_vals [3];
        chk_norm_mode_t cm;
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        norm_check_enable = 1'b0;
        shuffling_enable  = 1'b0;
        mode              = CHK_Z;
        randomness        = '0;
        mem_base_addr     = '0;
        exp_w             = words_of(CHK_Z);
        exp_invalid       = 1'b0;
        bases[0]          = 10'd0;
        bases[1]          = 10'd700;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (6) @(posedge clk);

        // Legal vectors holding the largest legal magnitude on both signs
        for (int m = 0; m < 3; m++) begin
            cm = chk_norm_mode_t'(m);
            for (int b = 0; b < 2; b++) begin
                fill_vector(cm, bases[b]);
                place_coef(cm, bases[b], bound_of(cm) - 1);
                place_coef(cm, bases[b], `NC_Q - bound_of(cm) + 1);
                start_op(cm, bases[b], 1'b0, '0);
                wait_ready();
            end
        end

        // One failing coefficient per run, at the bound, at q - bound and at q
        for (int m = 0; m < 3; m++) begin
            cm           = chk_norm_mode_t'(m);
            edge_vals[0] = bound_of(cm);
            edge_vals[1] = `NC_Q - bound_of(cm);
            edge_vals[2] = `NC_Q;
            for (int k = 0; k < 3; k++) begin
                fill_vector(cm, bases[k % 2]);
                place_coef(cm, bases[k % 2], edge_vals[k]);
                start_op(cm, bases[k % 2], 1'b0, '0);
                wait_ready();
            end
        end

        // Same vector shuffled, then unshuffled with randomness that must be ignored
        fill_vector(CHK_CT0, 10'd100);
        place_coef(CHK_CT0, 10'd100, `NC_Q - `NC_CT0_BOUND);
        start_op(CHK_CT0, 10'd100, 1'b1, word_idx_t'($random(seed)));
        wait_ready();
        start_op(CHK_CT0, 10'd100, 1'b0, word_idx_t'($random(seed)) | 6'd1);
        wait_ready();

        // Zeroize mid-vector, stay quiet past the aborted done, then rerun
        fill_vector(CHK_Z, 10'd0);
        place_coef(CHK_Z, 10'd0, `NC_Q);
        start_op(CHK_Z, 10'd0, 1'b0, '0);
        repeat (200) @(posedge clk);
        #1;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        repeat (words_of(CHK_Z) + 10) @(posedge clk);
        start_op(CHK_Z, 10'd0, 1'b0, '0);
        wait_ready();

        // Second start pulse in the middle of a busy operation
        fill_vector(CHK_R0, 10'd512);
        start_op(CHK_R0, 10'd512, 1'b1, word_idx_t'($random(seed)));
        repeat (100) @(posedge clk);
        #1;
        norm_check_enable = 1'b1;
        @(posedge clk);
        #1;
        norm_check_enable = 1'b0;
        wait_ready();

        repeat (4) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/norm_check_pkg.sv
hdl/norm_check.sv
hdl/norm_check_ctrl.sv
hdl/norm_check_top.sv
tests/tb_coef_mem.sv
tests/tb_norm_check.sv
